/* sources.f */
+incdir+verif
verilog/obj_dma_pkg.sv
verilog/obj_video_timing.sv
verilog/obj_src_ram.sv
verilog/obj_dma.sv
verilog/obj_table_ram.sv
verilog/obj_dma_top.sv
verif/obj_dma_tb.sv

/* Bender.yml */
package:
  name: obj_dma

sources:
  - verilog/obj_dma_pkg.sv
  - verilog/obj_video_timing.sv
  - verilog/obj_src_ram.sv
  - verilog/obj_dma.sv
  - verilog/obj_table_ram.sv
  - verilog/obj_dma_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/obj_dma_tb.sv

/* verif/obj_dma_model.svh */
// reference model of the sprite table clear and the priority sorted copy
`ifndef OBJ_DMA_MODEL_SVH
`define OBJ_DMA_MODEL_SVH

obj_word_t obj_list [0:2047];  // object RAM copy, 256 entries of 8 words
obj_word_t exp_tab  [0:2047];  // expected sprite table

// table slot picked by the priority byte of word 0
function automatic logic [7:0] slot_of(input logic [7:0] pri, input logic k44);
    if (k44) begin
        return {1'b0, pri[6:0]};  // forward order, lower half only
    end
    return {pri[7], ~pri[6:0]};   // reversed inside each half
endfunction

// enable bit, and priority 0 hides the entry in simson mode
function automatic logic shown(input obj_word_t w0, input logic simson);
    return w0[15] && !(simson && w0[7:0] == 8'd0);
endfunction

// clear the table, then copy the visible entries in address order
task automatic build_expected(input dma_mode_t m);
    int        n_clr;
    int        n_ent;
    int        a;
    logic [7:0] slot;
    obj_word_t w;
    n_clr = m.k44_en ? 1024 : 2048;
    n_ent = n_clr / 8;
    for (int i = 0; i < n_clr; i++) begin
        exp_tab[i] = '0;
    end
    for (int e = 0; e < n_ent; e++) begin
        if (!shown(obj_list[e*8], m.simson)) begin
            continue;
        end
        slot = slot_of(obj_list[e*8][7:0], m.k44_en);
        for (int k = 0; k < 7; k++) begin  // word 7 unused
            a = int'(slot) * 8 + k;
            w = obj_list[e*8+k];
            if (a % 2 == 1) begin
                exp_tab[a][15:8] = w[15:8];  // odd address, upper lane
            end else begin
                exp_tab[a][7:0] = w[7:0];
            end
        end
    end
endtask

// last enabled entry with priority byte 0, -1 when there is none
function automatic int last_zero_pri(input int n_ent);
    int last;
    last = -1;
    for (int e = 0; e < n_ent; e++) begin
        if (obj_list[e*8][15] && obj_list[e*8][7:0] == 8'd0) begin
            last = e;
        end
    end
    return last;
endfunction

`endif

/* verif/obj_dma_tb.sv */
// testbench for the sprite list DMA, random object lists checked against a table model
`timescale 1ns/10ps
`default_nettype none

module obj_dma_tb import obj_dma_pkg::*; ();

    localparam int H_TOTAL   = 64;   // short lines and frames keep runs quick
    localparam int H_SYNC    = 8;
    localparam int V_TOTAL   = 128;
    localparam int V_SYNC    = 4;
    localparam int FRAME_CLK = H_TOTAL * V_TOTAL * 2;  // one pixel every second clk
    localparam int N_FRAMES  = 24;                     // bound over all tests

    logic      clk;
    logic      rst;
    logic      cpu_we;
    src_addr_t cpu_addr;
    obj_word_t cpu_din;
    logic      dma_en;
    logic      dma_trig;
    dma_mode_t mode;
    tab_addr_t scan_addr;
    obj_word_t scan_data;
    logic      hs;
    logic      vs;
    logic      dma_bsy;
    logic      flicker;

    int          n_frame;     // frame starts seen on hs/vs
    int          n_flick;     // flicker toggles
    int          n_bsy_rise;  // runs started
    int          n_bsy_cyc;   // clk with dma_bsy high
    int          clk_n;       // clk since start
    int          fs_clk  = -1;  // clk count at the last frame start
    logic        hs_q    = 1'b0;
    logic        vs_hs   = 1'b0;
    logic        flick_q = 1'b0;
    logic        bsy_q   = 1'b0;
    int unsigned seed_draw;
    dma_mode_t   m;
    obj_word_t   d;
    int          len16;
    int          len8;
    int          len;
    int          e0;
    int          f0;
    int          t0;
    int          r0;
    int          b0;

    `include "obj_dma_model.svh"

    obj_dma_top #(
        .H_TOTAL (H_TOTAL),
        .H_SYNC  (H_SYNC),
        .V_TOTAL (V_TOTAL),
        .V_SYNC  (V_SYNC)
    ) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // output events, counted on the falling edge
    always @(negedge clk) begin
        clk_n   <= clk_n + 1;
        hs_q    <= hs;
        flick_q <= flicker;
        bsy_q   <= dma_bsy;
        if (hs && !hs_q) begin
            vs_hs <= vs;  // vs sampled at each hs rise
            if (vs_hs && !vs) begin
                n_frame <= n_frame + 1;
                if (fs_clk >= 0) begin  // whole frame of lines and pixels
                    check_eq(clk_n - fs_clk, FRAME_CLK, "clk between frame starts");
                end
                fs_clk <= clk_n;
            end
        end
        if (flicker !== flick_q) n_flick <= n_flick + 1;
        if (dma_bsy && !bsy_q) n_bsy_rise <= n_bsy_rise + 1;
        if (dma_bsy) n_bsy_cyc <= n_bsy_cyc + 1;
    end

    task automatic stop_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped on error");
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
            stop_run();
        end
    endtask

    // the byte lane that a table address holds, odd addresses use the upper lane
    function automatic logic [7:0] lane_of(input int a, input obj_word_t q);
        return (a % 2 == 1) ? q[15:8] : q[7:0];
    endfunction

    // counts falling edges until dma_bsy reaches the level
    task automatic wait_bsy(input logic level, input int limit, output int n);
        n = 0;
        while (dma_bsy !== level) begin
            @(negedge clk);
            n++;
            if (n > limit) begin
                $display("timeout at %0t: dma_bsy did not go to %0b", $time, level);
                stop_run();
            end
        end
    endtask

    task automatic wait_frames(input int n);
        int target;
        int t;
        target = n_frame + n;
        t      = 0;
        while (n_frame < target) begin
            @(negedge clk);
            t++;
            if (t > (n + 1) * FRAME_CLK) begin
                $display("timeout at %0t: no frame start on hs/vs", $time);
                stop_run();
            end
        end
        repeat (8) @(negedge clk);  // flicker and dma_bsy follow a few clk later
    endtask

    // random list, some entries enabled with priority 0
    task automatic load_list();
        obj_word_t w;
        for (int i = 0; i < 2048; i++) begin
            w = obj_word_t'($urandom);
            if (i % 8 == 0 && $urandom % 8 == 0) w = {1'b1, w[14:8], 8'h00};
            obj_list[i] = w;
            @(posedge clk);
            #1 cpu_we = 1'b1;
            cpu_addr  = src_addr_t'(i);
            cpu_din   = w;
        end
        @(posedge clk);
        #1 cpu_we = 1'b0;
    endtask

    task automatic read_tab(input int a, output obj_word_t q);
        @(posedge clk);
        #1 scan_addr = tab_addr_t'(a);
        @(posedge clk);
        @(negedge clk);
        q = scan_data;
    endtask

    // only the lane that the DMA writes at each address is held
    task automatic compare_table();
        obj_word_t q;
        for (int a = 0; a < 2048; a++) begin
            read_tab(a, q);
            check_eq(lane_of(a, q), lane_of(a, exp_tab[a]), $sformatf("table word %03h", a));
        end
    endtask

    // one run from a frame start or a trigger, len is dma_bsy high time in clk
    task automatic run_dma(input dma_mode_t mm, input logic use_trig, output int n);
        int w;
        @(posedge clk);
        #1 mode = mm;
        if (use_trig) begin
            dma_trig = 1'b1;
            @(posedge clk);
            #1 dma_trig = 1'b0;
        end else begin
            dma_en = 1'b1;
        end
        wait_bsy(1'b1, 2 * FRAME_CLK, w);
        @(posedge clk);
        #1 dma_en = 1'b0;  // one run only
        wait_bsy(1'b0, FRAME_CLK, n);
        n = n + 1;         // falling edge where the rise was seen
    endtask

    // clear words plus 7 copy cycles per entry, two clk per enabled cycle
    task automatic check_len(input dma_mode_t mm, input int n);
        int clr_n;
        int min_n;
        clr_n = mm.k44_en ? 1024 : 2048;
        min_n = 2 * (clr_n + 7 * (clr_n / 8));
        check_eq(n >= min_n && n <= min_n + 8, 1,
                 $sformatf("run length %0d clk, about %0d expected", n, min_n));
    endtask

    initial begin
        seed_draw = $urandom(32'h78f90a45);
        rst       = 1'b1;
        cpu_we    = 1'b0;
        cpu_addr  = '0;
        cpu_din   = '0;
        dma_en    = 1'b0;
        dma_trig  = 1'b0;
        mode      = '0;
        scan_addr = '0;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;

        // default mode on a frame start, priority 0 entries are copied
        m = '0;
        load_list();
        run_dma(m, 1'b0, len16);
        check_len(m, len16);
        build_expected(m);
        compare_table();
        e0 = last_zero_pri(256);
        check_eq(e0 >= 0, 1, "enabled priority 0 entry in list");
        read_tab('h3f9, d);  // slot 7f word 1, upper lane
        check_eq(d[15:8], obj_list[e0*8+1][15:8], "priority 0 entry copied");

        // 8-bit bus, same list, longer run and same table
        m.mode8 = 1'b1;
        run_dma(m, 1'b0, len8);
        check_eq(len8 > len16, 1, $sformatf("8-bit run %0d clk vs %0d clk", len8, len16));
        build_expected(m);
        compare_table();

        // 053244 layout skips the wait and clears the lower half only
        m.k44_en = 1'b1;
        load_list();
        run_dma(m, 1'b0, len);
        check_len(m, len);
        build_expected(m);
        compare_table();

        // simson hides priority 0
        m        = '0;
        m.simson = 1'b1;
        load_list();
        run_dma(m, 1'b0, len);
        check_len(m, len);
        build_expected(m);
        compare_table();
        for (int k = 0; k < 7; k++) begin
            read_tab('h3f8 + k, d);
            check_eq(lane_of('h3f8 + k, d), 0, "priority 0 slot stays clear");
        end

        // dma_en low, flicker only, then a trigger runs the DMA
        m = '0;
        load_list();
        wait_frames(1);
        t0 = n_flick;
        b0 = n_bsy_cyc;
        wait_frames(2);
        check_eq(n_flick - t0, 2, "flicker toggles with dma_en low");
        check_eq(n_bsy_cyc - b0, 0, "dma_bsy low with dma_en low");
        run_dma(m, 1'b1, len);
        check_len(m, len);
        build_expected(m);
        compare_table();

        // three frames with dma_en high, one run and one toggle each
        wait_frames(1);
        t0 = n_flick;
        r0 = n_bsy_rise;
        @(posedge clk);
        #1 dma_en = 1'b1;
        wait_frames(3);
        @(posedge clk);
        #1 dma_en = 1'b0;
        wait_bsy(1'b0, FRAME_CLK, len);
        check_eq(n_flick - t0, 3, "flicker toggles per frame");
        check_eq(n_bsy_rise - r0, 3, "one run per frame");

        // triggered in vsync, the frame start lands in the run and is dropped
        len = 0;
        while (!vs) begin
            @(negedge clk);
            len++;
            if (len > FRAME_CLK) begin
                $display("timeout at %0t: vs never went high", $time);
                stop_run();
            end
        end
        f0 = n_frame;
        t0 = n_flick;
        r0 = n_bsy_rise;
        @(posedge clk);
        #1 dma_en = 1'b1;
        dma_trig  = 1'b1;
        @(posedge clk);
        #1 dma_trig = 1'b0;
        wait_bsy(1'b1, 64, len);
        wait_bsy(1'b0, FRAME_CLK, len);
        repeat (200) @(negedge clk);
        check_eq(n_frame - f0, 1, "frame start during run");
        check_eq(n_bsy_rise - r0, 1, "no second run");
        check_eq(n_flick - t0, 0, "flicker held while busy");
        @(posedge clk);
        #1 dma_en = 1'b0;

        $display("Simulation finished: PASS");
        $finish;
    end

    // ends a run that stalls
    initial begin
        #(N_FRAMES * FRAME_CLK * 10);
        $display("watchdog at %0t: tests did not finish within %0d frames", $time, N_FRAMES);
        stop_run();
    end

endmodule

`default_nettype wire

/* verilog/obj_dma_top.sv */
// sprite list DMA subsystem with video timing, object RAM, DMA engine and sprite table
`timescale 1ns/10ps
`default_nettype none

module obj_dma_top import obj_dma_pkg::*; #(
    parameter int H_TOTAL = DEF_H_TOTAL,
    parameter int H_SYNC  = DEF_H_SYNC,
    parameter int V_TOTAL = DEF_V_TOTAL,
    parameter int V_SYNC  = DEF_V_SYNC
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      cpu_we,
    input  src_addr_t cpu_addr,
    input  obj_word_t cpu_din,
    input  logic      dma_en,
    input  logic      dma_trig,
    input  dma_mode_t mode,
    input  tab_addr_t scan_addr,
    output obj_word_t scan_data,
    output logic      hs,
    output logic      vs,
    output logic      dma_bsy,
    output logic      flicker
);

    logic      pxl2_cen;
    src_addr_t src_addr;  // DMA read address
    obj_word_t src_data;
    tab_wr_t   tab_wr;    // DMA to table

    obj_video_timing #(
        .H_TOTAL (H_TOTAL),
        .H_SYNC  (H_SYNC),
        .V_TOTAL (V_TOTAL),
        .V_SYNC  (V_SYNC)
    ) u_timing (
        .clk      (clk),
        .rst      (rst),
        .pxl2_cen (pxl2_cen),
        .hs       (hs),
        .vs       (vs)
    );

    obj_src_ram u_src_ram (
        .clk      (clk),
        .cpu_we   (cpu_we),
        .cpu_addr (cpu_addr),
        .cpu_din  (cpu_din),
        .rd_addr  (src_addr),
        .rd_data  (src_data)
    );

    obj_dma u_dma (
        .clk      (clk),
        .rst      (rst),
        .pxl2_cen (pxl2_cen),
        .hs       (hs),
        .vs       (vs),
        .dma_en   (dma_en),
        .dma_trig (dma_trig),
        .mode     (mode),
        .src_addr (src_addr),
        .src_data (src_data),
        .tab_wr   (tab_wr),
        .dma_bsy  (dma_bsy),
        .flicker  (flicker)
    );

    obj_table_ram u_table_ram (
        .clk       (clk),
        .wr        (tab_wr),
        .scan_addr (scan_addr),
        .scan_data (scan_data)
    );

endmodule

`default_nettype wire

/* verilog/obj_table_ram.sv */
// sprite table buffer with byte lane writes and a registered scan read port
`timescale 1ns/10ps
`default_nettype none

module obj_table_ram import obj_dma_pkg::*; (
    input  logic      clk,
    input  tab_wr_t   wr,         // DMA write bus
    input  tab_addr_t scan_addr,  // renderer side
    output obj_word_t scan_data   // one clk after scan_addr
);

    localparam int DEPTH = 2 ** $bits(tab_addr_t);  // 2K words

    logic [7:0] mem_hi [0:DEPTH-1];  // upper byte lane
    logic [7:0] mem_lo [0:DEPTH-1];  // lower byte lane

    always_ff @(posedge clk) begin
        if (wr.weh) begin
            mem_hi[wr.addr] <= wr.din[15:8];
        end
        if (wr.wel) begin
            mem_lo[wr.addr] <= wr.din[7:0];
        end
    end

    // scan read
    always_ff @(posedge clk) begin
        scan_data <= {mem_hi[scan_addr], mem_lo[scan_addr]};
    end

endmodule

`default_nettype wire

/* verilog/obj_dma.sv */
// sprite list DMA that clears the table and copies visible entries by priority slot
`timescale 1ns/10ps
`default_nettype none

module obj_dma import obj_dma_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      pxl2_cen,
    input  logic      hs,
    input  logic      vs,
    input  logic      dma_en,    // run on frame start
    input  logic      dma_trig,  // one clk request
    input  dma_mode_t mode,
    output src_addr_t src_addr,
    input  obj_word_t src_data,  // mem[src_addr] at each enabled cycle
    output tab_wr_t   tab_wr,
    output logic      dma_bsy,
    output logic      flicker
);

    dma_state_t state;
    dma_mode_t  mode_q;       // mode held for the whole run
    tab_addr_t  cnt;          // clear address, then wait count
    logic       hsl;          // hs one enabled cycle ago
    logic       vs_l;         // vs sampled on last hs rise
    logic       hs_pos;
    logic       frame_start;
    logic       start;
    logic       trig_pend;
    logic       drain;        // last word read, final write pending
    logic       wr_pend;      // buffered word to write this cycle
    logic       buf_ok;       // current entry is visible
    logic [7:0] buf_slot;     // table slot of current entry
    logic [2:0] buf_word;
    obj_word_t  buf_d;
    logic [7:0] slot_nx;
    logic       visible;
    logic       last_entry;
    logic       clr_last;
    logic       tab_we;

    assign hs_pos      = hs & ~hsl;
    assign frame_start = hs_pos & vs_l & ~vs;  // vs went 1 to 0 between hs rises
    assign start       = (state == st_idle) & (frame_start | trig_pend);

    // 053246 reverses priority within each half, 053244 keeps it and uses half the table
    assign slot_nx = mode_q.k44_en ? {1'b0, src_data[6:0]} : {src_data[7], ~src_data[6:0]};
    assign visible = src_data[15] & ((src_data[7:0] != 8'd0) | ~mode_q.simson);

    assign last_entry = mode_q.k44_en ? (src_addr[9:3] == 7'h7f) : (src_addr[10:3] == 8'hff);
    assign clr_last   = mode_q.k44_en ? (cnt[9:0] == 10'h3ff) : (cnt == 11'h7ff);

    // table write bus, one byte lane per enabled cycle picked by addr bit 0
    always_comb begin
        if (state == st_clear) begin
            tab_wr.addr = cnt;
            tab_wr.din  = '0;
            tab_we      = pxl2_cen;
        end else begin
            tab_wr.addr = {buf_slot, buf_word};
            tab_wr.din  = buf_d;
            tab_we      = pxl2_cen & wr_pend & buf_ok;
        end
        tab_wr.wel = tab_we & ~tab_wr.addr[0];
        tab_wr.weh = tab_we &  tab_wr.addr[0];
    end

    // trigger stays pending until a run takes it
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            trig_pend <= 1'b0;
        end else begin
            if (pxl2_cen && start) trig_pend <= 1'b0;
            if (dma_trig)          trig_pend <= 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= st_idle;
            mode_q   <= '0;
            cnt      <= '0;
            src_addr <= '0;
            hsl      <= 1'b0;
            vs_l     <= 1'b0;
            dma_bsy  <= 1'b0;
            flicker  <= 1'b0;
            drain    <= 1'b0;
            wr_pend  <= 1'b0;
            buf_ok   <= 1'b0;
            buf_slot <= '0;
            buf_word <= '0;
        end else if (pxl2_cen) begin
            hsl     <= hs;
            wr_pend <= 1'b0;
            if (hs_pos) vs_l <= vs;
            if (start && frame_start) flicker <= ~flicker;  // even with dma_en low
            case (state)
                st_idle: begin
                    cnt      <= '0;
                    src_addr <= '0;  // entry 0 word 0 is ready when copy begins
                    drain    <= 1'b0;
                    if (start && (dma_en || trig_pend)) begin
                        state   <= st_clear;
                        mode_q  <= mode;
                        dma_bsy <= 1'b1;
                    end
                end
                st_clear: begin
                    cnt <= cnt + 11'd1;
                    if (clr_last) begin
                        cnt   <= '0;
                        state <= (mode_q.mode8 && !mode_q.k44_en) ? st_wait : st_copy;
                    end
                end
                st_wait: begin
                    cnt <= cnt + 11'd1;
                    if (cnt == tab_addr_t'(WAIT_CYCLES - 1)) state <= st_copy;
                end
                st_copy: begin
                    if (!drain) begin
                        buf_word <= src_addr[2:0];
                        wr_pend  <= 1'b1;          // written next enabled cycle
                        if (src_addr[2:0] == 3'd0) begin
                            buf_slot <= slot_nx;   // word 0 holds priority and enable
                            buf_ok   <= visible;
                        end
                        if (src_addr[2:0] == 3'd6) begin
                            src_addr <= src_addr + 13'd2;  // word 7 unused
                            drain    <= last_entry;
                        end else begin
                            src_addr <= src_addr + 13'd1;
                        end
                    end else begin
                        state   <= st_idle;
                        dma_bsy <= 1'b0;  // last word written this cycle
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // copy data buffer
    always_ff @(posedge clk) begin
        if (pxl2_cen && state == st_copy && !drain) begin
            buf_d <= src_data;
        end
    end

    // no table writes once a run has finished
    a_wr_in_run: assert property (
        @(posedge clk) disable iff (rst)
        (tab_wr.weh || tab_wr.wel) |-> (dma_bsy || state == st_clear)
    ) else $error("sprite table write outside a DMA run");

    a_one_lane: assert property (
        @(posedge clk) disable iff (rst) !(tab_wr.weh && tab_wr.wel)
    ) else $error("both table byte lanes written at once");

endmodule

`default_nettype wire

/* verilog/obj_src_ram.sv */
// object RAM with a CPU write port and a registered DMA read port
`timescale 1ns/10ps
`default_nettype none

module obj_src_ram import obj_dma_pkg::*; (
    input  logic      clk,
    input  logic      cpu_we,
    input  src_addr_t cpu_addr,
    input  obj_word_t cpu_din,
    input  src_addr_t rd_addr,   // DMA side
    output obj_word_t rd_data    // valid one clk after rd_addr
);

    localparam int DEPTH = 2 ** $bits(src_addr_t);  // 8K words

    obj_word_t mem [0:DEPTH-1];

    // CPU write
    always_ff @(posedge clk) begin
        if (cpu_we) begin
            mem[cpu_addr] <= cpu_din;
        end
    end

    // DMA read, one clk latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

    // a CPU write must hit a known location
    a_cpu_addr_known: assert property (
        @(posedge clk) cpu_we |-> !$isunknown(cpu_addr)
    ) else $error("object RAM write with unknown address");

endmodule

`default_nettype wire

/* verilog/obj_video_timing.sv */
// video timing generator with pixel clock enable and hs/vs sync levels
`timescale 1ns/10ps
`default_nettype none

module obj_video_timing import obj_dma_pkg::*; #(
    parameter int H_TOTAL = DEF_H_TOTAL,  // pixels per line
    parameter int H_SYNC  = DEF_H_SYNC,   // hs width in pixels
    parameter int V_TOTAL = DEF_V_TOTAL,  // lines per frame
    parameter int V_SYNC  = DEF_V_SYNC    // vs width in lines
) (
    input  logic clk,
    input  logic rst,
    output logic pxl2_cen,  // every second clk
    output logic hs,
    output logic vs
);

    localparam int HW = $clog2(H_TOTAL);
    localparam int VW = $clog2(V_TOTAL);

    localparam logic [HW-1:0] H_LAST  = HW'(H_TOTAL - 1);
    localparam logic [HW-1:0] H_START = HW'(H_TOTAL - H_SYNC);  // first hs pixel
    localparam logic [VW-1:0] V_LAST  = VW'(V_TOTAL - 1);
    localparam logic [VW-1:0] V_START = VW'(V_TOTAL - V_SYNC);  // first vs line

    logic [HW-1:0] hcnt;  // pixel in line
    logic [VW-1:0] vcnt;  // line in frame

    // clk divided by two
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pxl2_cen <= 1'b0;
        end else begin
            pxl2_cen <= ~pxl2_cen;
        end
    end

    // counters step on pixel enable only
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (pxl2_cen) begin
            if (hcnt == H_LAST) begin
                hcnt <= '0;
                if (vcnt == V_LAST) begin
                    vcnt <= '0;  // new frame
                end else begin
                    vcnt <= vcnt + 1'b1;
                end
            end else begin
                hcnt <= hcnt + 1'b1;
            end
        end
    end

    // sync levels at the end of line and frame, one pixel behind the counters
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hs <= 1'b0;
            vs <= 1'b0;
        end else if (pxl2_cen) begin
            hs <= hcnt >= H_START;
            vs <= vcnt >= V_START;
        end
    end

endmodule

`default_nettype wire

/* verilog/obj_dma_pkg.sv */
// shared types and constants for the sprite list DMA, its object RAM and its sprite table
`default_nettype none

package obj_dma_pkg;

    // default pixel timing, in pixels and lines
    localparam int DEF_H_TOTAL = 384;
    localparam int DEF_H_SYNC  = 32;
    localparam int DEF_V_TOTAL = 264;
    localparam int DEF_V_SYNC  = 8;

    // extra enabled cycles in 8-bit bus mode, matches the slower original bus
    localparam int WAIT_CYCLES = 2024;

    typedef logic [15:0] obj_word_t;  // one RAM word
    typedef logic [12:0] src_addr_t;  // word address, 16 KB object RAM
    typedef logic [10:0] tab_addr_t;  // word address, sprite table

    // DMA operating mode
    typedef struct packed {
        logic mode8;   // 8-bit bus speed
        logic k44_en;  // 053244 layout with half table and forward priority
        logic simson;  // priority 0 hides the sprite
    } dma_mode_t;

    // write bus from the DMA into the sprite table
    typedef struct packed {
        logic      weh;   // upper byte lane
        logic      wel;   // lower byte lane
        tab_addr_t addr;
        obj_word_t din;
    } tab_wr_t;

    // DMA phases
    typedef enum logic [1:0] {
        st_idle,
        st_clear,
        st_wait,
        st_copy
    } dma_state_t;

endpackage

`default_nettype wire
